/* source/isa_pkg.sv */
package isa_pkg;

    localparam int word_width = 16;
    localparam int addr_width = 9;   // 512-word memory
    localparam int reg_count = 8;

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] mem_addr_t;
    typedef logic [$clog2(reg_count)-1:0] reg_num_t;

    // instruction bits 15:13
    typedef enum logic [2:0]
    {
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_alu  = 3'b101,
        op_mov  = 3'b110,
        op_halt = 3'b111
    } opcode_e;

    // instruction bits 12:11
    typedef enum logic [1:0]
    {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_e;

    // the op field of a move selects its source
    localparam alu_op_e mov_imm = alu_and;
    localparam alu_op_e mov_reg = alu_add;

    // instruction bits 4:3, applied to the B operand
    typedef enum logic [1:0]
    {
        shift_none = 2'b00,
        shift_left = 2'b01,   // left by one
        shift_lsr  = 2'b10,   // logical right by one
        shift_asr  = 2'b11    // arithmetic right by one
    } shift_e;

endpackage

/* source/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    typedef enum logic [1:0]
    {
        mem_none  = 2'b00,
        mem_read  = 2'b01,
        mem_write = 2'b11
    } mem_cmd_e;

    typedef enum logic [3:0]
    {
        st_reset,
        st_fetch1,
        st_fetch2,
        st_update,   // pc increment
        st_decode,
        st_exec1,
        st_exec2,
        st_exec3,
        st_exec4,
        st_exec5,
        st_exec6,
        st_halt
    } ctrl_state_e;

    // instruction field that names the register file port
    typedef enum logic [1:0]
    {
        sel_rn,
        sel_rd,
        sel_rm
    } reg_sel_e;

    typedef enum logic [1:0]
    {
        src_c,
        src_sximm8,
        src_mdata
    } write_src_e;

endpackage

/* source/datapath_ctrl_if.sv */
`timescale 1ns/10ps

interface datapath_ctrl_if;
    import cpu_ctrl_pkg::*;

    reg_sel_e   reg_sel;
    write_src_e write_src;
    logic       reg_write;
    logic       load_a;
    logic       load_b;
    logic       load_c;
    logic       load_s;      // status flags
    logic       a_zero;      // A operand forced to zero
    logic       b_imm;       // B operand replaced by sximm5

    modport ctrl
    (
        output reg_sel, write_src, reg_write, load_a, load_b, load_c, load_s,
               a_zero, b_imm
    );

    modport dp
    (
        input write_src, reg_write, load_a, load_b, load_c, load_s, a_zero, b_imm
    );

    modport dec (input reg_sel);

endinterface

/* source/instr_fields_if.sv */
`timescale 1ns/10ps

interface instr_fields_if;
    import isa_pkg::*;

    reg_num_t reg_num;   // already picked from rn, rd or rm
    shift_e   shift;
    alu_op_e  alu_op;
    word_t    sximm5;
    word_t    sximm8;

    modport dec
    (
        output reg_num, shift, alu_op, sximm5, sximm8
    );

    modport dp
    (
        input reg_num, shift, alu_op, sximm5, sximm8
    );

endinterface

/* source/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
(
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::word_t   read_data,
    input  logic             load_ir,
    datapath_ctrl_if.dec     ctrl,
    instr_fields_if.dec      fields,
    output isa_pkg::opcode_e opcode,
    output isa_pkg::alu_op_e op
);
    import isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t ir;
    logic  mem_instr;

    always_ff @(posedge clk)
    begin
        if (reset)
            ir <= '0;
        else if (load_ir)
            ir <= read_data;
    end

    assign opcode = opcode_e'(ir[15:13]);
    assign op = alu_op_e'(ir[12:11]);
    assign mem_instr = (opcode == op_ldr) || (opcode == op_str);

    // loads and stores reuse bits 4:3 as part of imm5
    assign fields.shift = mem_instr ? shift_none : shift_e'(ir[4:3]);
    assign fields.alu_op = mem_instr ? alu_add : op;   // address is Rn + sximm5

    assign fields.sximm5 = {{(word_width-5){ir[4]}}, ir[4:0]};
    assign fields.sximm8 = {{(word_width-8){ir[7]}}, ir[7:0]};

    always_comb
    begin
        case (ctrl.reg_sel)
            sel_rd:  fields.reg_num = ir[7:5];
            sel_rm:  fields.reg_num = ir[2:0];
            default: fields.reg_num = ir[10:8];
        endcase
    end

endmodule

/* source/cpu_controller.sv */
`timescale 1ns/10ps

module cpu_controller
(
    input  logic                   clk,
    input  logic                   reset,
    input  isa_pkg::opcode_e       opcode,
    input  isa_pkg::alu_op_e       op,
    datapath_ctrl_if.ctrl          ctrl,
    output logic                   load_ir,
    output logic                   load_pc,
    output logic                   pc_clear,
    output logic                   load_addr,
    output logic                   addr_sel_pc,
    output cpu_ctrl_pkg::mem_cmd_e mem_cmd
);
    import isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        last_exec;     // final execute state of this instruction
    logic        known_instr;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_reset;
        else
            state <= next_state;
    end

    // branches and anything else unlisted end up in halt
    assign known_instr = (opcode inside {op_alu, op_ldr, op_str}) ||
                         (opcode == op_mov && (op == mov_imm || op == mov_reg));

    always_comb
    begin
        ctrl.reg_sel = sel_rn;
        ctrl.write_src = src_c;
        ctrl.reg_write = 1'b0;
        ctrl.load_a = 1'b0;
        ctrl.load_b = 1'b0;
        ctrl.load_c = 1'b0;
        ctrl.load_s = 1'b0;
        ctrl.a_zero = 1'b0;
        ctrl.b_imm = 1'b0;
        load_ir = 1'b0;
        load_pc = 1'b0;
        pc_clear = 1'b0;
        load_addr = 1'b0;
        addr_sel_pc = 1'b0;
        mem_cmd = mem_none;
        last_exec = 1'b0;

        case (state)
            st_reset:
            begin
                load_pc = 1'b1;
                pc_clear = 1'b1;
            end
            st_fetch1:
            begin
                addr_sel_pc = 1'b1;
                mem_cmd = mem_read;
            end
            st_fetch2:
            begin
                addr_sel_pc = 1'b1;
                mem_cmd = mem_read;
                load_ir = 1'b1;
            end
            st_update: load_pc = 1'b1;
            st_exec1:
            begin
                if (opcode == op_mov && op == mov_imm)
                begin
                    ctrl.write_src = src_sximm8;   // into Rn
                    ctrl.reg_write = 1'b1;
                    last_exec = 1'b1;
                end
                else if (opcode == op_mov)
                begin
                    ctrl.reg_sel = sel_rm;
                    ctrl.load_b = 1'b1;
                end
                else
                    ctrl.load_a = 1'b1;
            end
            st_exec2:
            begin
                if (opcode == op_mov)
                begin
                    ctrl.a_zero = 1'b1;            // C gets shifted Rm
                    ctrl.load_c = 1'b1;
                end
                else if (opcode == op_alu)
                begin
                    ctrl.reg_sel = sel_rm;
                    ctrl.load_b = 1'b1;
                end
                else
                begin
                    ctrl.b_imm = 1'b1;             // effective address into C
                    ctrl.load_c = 1'b1;
                end
            end
            st_exec3:
            begin
                if (opcode == op_mov)
                begin
                    ctrl.reg_sel = sel_rd;
                    ctrl.reg_write = 1'b1;
                    last_exec = 1'b1;
                end
                else if (opcode == op_alu && op == alu_cmp)
                begin
                    ctrl.load_s = 1'b1;
                    last_exec = 1'b1;
                end
                else if (opcode == op_alu)
                    ctrl.load_c = 1'b1;
                else
                    load_addr = 1'b1;
            end
            st_exec4:
            begin
                if (opcode == op_alu)
                begin
                    ctrl.reg_sel = sel_rd;
                    ctrl.reg_write = 1'b1;
                    last_exec = 1'b1;
                end
                else if (opcode == op_ldr)
                    mem_cmd = mem_read;
                else
                begin
                    ctrl.reg_sel = sel_rd;         // store data goes through B
                    ctrl.load_b = 1'b1;
                end
            end
            st_exec5:
            begin
                if (opcode == op_ldr)
                begin
                    mem_cmd = mem_read;            // read data is valid this cycle
                    ctrl.reg_sel = sel_rd;
                    ctrl.write_src = src_mdata;
                    ctrl.reg_write = 1'b1;
                    last_exec = 1'b1;
                end
                else
                begin
                    ctrl.a_zero = 1'b1;
                    ctrl.load_c = 1'b1;
                end
            end
            st_exec6:
            begin
                mem_cmd = mem_write;               // memory takes out at data address
                last_exec = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        case (state)
            st_reset:  next_state = st_fetch1;
            st_fetch1: next_state = st_fetch2;
            st_fetch2: next_state = st_update;
            st_update: next_state = st_decode;
            st_decode: next_state = known_instr ? st_exec1 : st_halt;
            st_exec1:  next_state = st_exec2;
            st_exec2:  next_state = st_exec3;
            st_exec3:  next_state = st_exec4;
            st_exec4:  next_state = st_exec5;
            st_exec5:  next_state = st_exec6;
            st_exec6:  next_state = st_fetch1;
            default:   next_state = st_halt;   // stays until reset
        endcase
        if (last_exec)
            next_state = st_fetch1;
    end

endmodule

/* source/datapath.sv */
`timescale 1ns/10ps

module datapath
(
    input  logic           clk,
    input  isa_pkg::word_t read_data,
    datapath_ctrl_if.dp    ctrl,
    instr_fields_if.dp     fields,
    output isa_pkg::word_t out,
    output logic           n,
    output logic           v,
    output logic           z
);
    import isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int msb = word_width - 1;

    word_t regs [reg_count];
    word_t a_reg;
    word_t b_reg;
    word_t c_reg;
    word_t write_data;
    word_t b_shifted;
    word_t alu_a;
    word_t alu_b;
    word_t diff;
    word_t alu_result;

    always_comb
    begin
        case (ctrl.write_src)
            src_sximm8: write_data = fields.sximm8;
            src_mdata:  write_data = read_data;
            default:    write_data = c_reg;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.reg_write)
            regs[fields.reg_num] <= write_data;
        if (ctrl.load_a)
            a_reg <= regs[fields.reg_num];
        if (ctrl.load_b)
            b_reg <= regs[fields.reg_num];
        if (ctrl.load_c)
            c_reg <= alu_result;
    end

    always_comb
    begin
        case (fields.shift)
            shift_left: b_shifted = {b_reg[msb-1:0], 1'b0};
            shift_lsr:  b_shifted = {1'b0, b_reg[msb:1]};
            shift_asr:  b_shifted = {b_reg[msb], b_reg[msb:1]};
            default:    b_shifted = b_reg;
        endcase
    end

    assign alu_a = ctrl.a_zero ? '0 : a_reg;
    assign alu_b = ctrl.b_imm ? fields.sximm5 : b_shifted;
    assign diff = alu_a - alu_b;

    always_comb
    begin
        case (fields.alu_op)
            alu_cmp: alu_result = diff;
            alu_and: alu_result = alu_a & alu_b;
            alu_mvn: alu_result = ~alu_b;
            default: alu_result = alu_a + alu_b;
        endcase
    end

    // flags always describe A - B
    always_ff @(posedge clk)
    begin
        if (ctrl.load_s)
        begin
            z <= (diff == '0);
            n <= diff[msb];
            v <= (alu_a[msb] != alu_b[msb]) && (diff[msb] != alu_a[msb]);
        end
    end

    assign out = c_reg;

endmodule

/* source/address_unit.sv */
`timescale 1ns/10ps

module address_unit
(
    input  logic               clk,
    input  logic               load_pc,
    input  logic               pc_clear,
    input  logic               load_addr,
    input  logic               addr_sel_pc,
    input  isa_pkg::word_t     c_value,
    output isa_pkg::mem_addr_t mem_addr
);
    import isa_pkg::*;

    mem_addr_t pc;
    mem_addr_t data_addr;

    // no branches, so the pc only clears or counts up
    always_ff @(posedge clk)
    begin
        if (load_pc)
        begin
            if (pc_clear)
                pc <= '0;
            else
                pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_addr)
            data_addr <= c_value[addr_width-1:0];   // upper bits of C ignored
    end

    assign mem_addr = addr_sel_pc ? pc : data_addr;

endmodule

/* source/cpu.sv */
`timescale 1ns/10ps

module cpu
(
    input  logic                   clk,
    input  logic                   reset,
    input  isa_pkg::word_t         read_data,
    output isa_pkg::word_t         out,
    output logic                   n,
    output logic                   v,
    output logic                   z,
    output cpu_ctrl_pkg::mem_cmd_e mem_cmd,
    output isa_pkg::mem_addr_t     mem_addr
);
    import isa_pkg::*;

    opcode_e opcode;
    alu_op_e op;
    logic    load_ir;
    logic    load_pc;
    logic    pc_clear;
    logic    load_addr;
    logic    addr_sel_pc;

    datapath_ctrl_if ctrl_bus();
    instr_fields_if  fields_bus();

    instr_decoder decoder
    (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .load_ir   (load_ir),
        .ctrl      (ctrl_bus),
        .fields    (fields_bus),
        .opcode    (opcode),
        .op        (op)
    );

    cpu_controller controller
    (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .op          (op),
        .ctrl        (ctrl_bus),
        .load_ir     (load_ir),
        .load_pc     (load_pc),
        .pc_clear    (pc_clear),
        .load_addr   (load_addr),
        .addr_sel_pc (addr_sel_pc),
        .mem_cmd     (mem_cmd)
    );

    datapath dp
    (
        .clk       (clk),
        .read_data (read_data),
        .ctrl      (ctrl_bus),
        .fields    (fields_bus),
        .out       (out),
        .n         (n),
        .v         (v),
        .z         (z)
    );

    address_unit addr_unit
    (
        .clk         (clk),
        .load_pc     (load_pc),
        .pc_clear    (pc_clear),
        .load_addr   (load_addr),
        .addr_sel_pc (addr_sel_pc),
        .c_value     (out),
        .mem_addr    (mem_addr)
    );

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/10ps

module tb_memory
(
    input  logic                   clk,
    input  cpu_ctrl_pkg::mem_cmd_e mem_cmd,
    input  isa_pkg::mem_addr_t     mem_addr,
    input  isa_pkg::word_t         write_data,
    output isa_pkg::word_t         read_data
);
    import isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t words [1 << addr_width];   // also loaded directly by the testbench

    // answers in the same cycle as the read command
    assign read_data = (mem_cmd == mem_read) ? words[mem_addr] : '0;

    always @(posedge clk)
    begin
        if (mem_cmd == mem_write)
            words[mem_addr] = write_data;
    end

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;
    import isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic      clk;
    logic      reset;
    word_t     read_data;
    word_t     out;
    logic      n;
    logic      v;
    logic      z;
    mem_cmd_e  mem_cmd;
    mem_addr_t mem_addr;

    word_t       exp_mem [1 << addr_width];   // expected memory image
    mem_addr_t   prog_pc;
    string       test_name;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_budget = 0;
    logic [31:0] lfsr_state = 32'ha06f_002c;

    cpu UUT
    (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .out       (out),
        .n         (n),
        .v         (v),
        .z         (z),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr)
    );

    tb_memory memory
    (
        .clk        (clk),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (out),
        .read_data  (read_data)
    );

    initial
        clk = 1'b0;

    always #4 clk = ~clk;

    function logic lfsr_bit();
        lfsr_bit = lfsr_state[0];
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
    endfunction

    function word_t random_bits(input int count);
        word_t value;
        int    i;
        value = '0;
        for (i = 0; i < count; i++)
            value = {value[14:0], lfsr_bit()};
        return value;
    endfunction

    function word_t fill_word(input mem_addr_t a);
        return {a[8:2], a} ^ 16'h3c5a;
    endfunction

    function word_t shifted(input word_t x, input shift_e sh);
        case (sh)
            shift_left: return x << 1;
            shift_lsr:  return x >> 1;
            shift_asr:  return word_t'($signed(x) >>> 1);
            default:    return x;
        endcase
    endfunction

    // field layout op[15:13] sub[12:11] rn[10:8] rd[7:5] sh[4:3] rm[2:0]
    function word_t mov_imm_instr(input reg_num_t rn, input logic [7:0] imm8);
        return {3'b110, 2'b10, rn, imm8};
    endfunction

    function word_t mov_reg_instr(input reg_num_t rd, input shift_e sh, input reg_num_t rm);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function word_t alu_instr(input logic [1:0] sub, input reg_num_t rn, input reg_num_t rd,
                              input shift_e sh, input reg_num_t rm);
        return {3'b101, sub, rn, rd, sh, rm};
    endfunction

    function word_t ldr_instr(input reg_num_t rd, input reg_num_t rn, input logic [4:0] imm5);
        return {3'b011, 2'b00, rn, rd, imm5};
    endfunction

    function word_t str_instr(input reg_num_t rd, input reg_num_t rn, input logic [4:0] imm5);
        return {3'b100, 2'b00, rn, rd, imm5};
    endfunction

    // fetch, update and decode plus the execute states
    function int instr_cycles(input word_t w);
        case (w[15:13])
            3'b110:  return (w[12:11] == 2'b10) ? 5 : 7;
            3'b101:  return (w[12:11] == 2'b01) ? 7 : 8;
            3'b011:  return 9;
            3'b100:  return 10;
            default: return 4;
        endcase
    endfunction

    task new_program(input string name);
        int i;
        test_name = name;
        prog_pc = '0;
        for (i = 0; i < (1 << addr_width); i++)
        begin
            memory.words[i] = fill_word(mem_addr_t'(i));
            exp_mem[i] = fill_word(mem_addr_t'(i));
        end
    endtask

    task emit(input word_t w);
        memory.words[prog_pc] = w;
        exp_mem[prog_pc] = w;
        prog_pc++;
        cycle_budget += instr_cycles(w);
    endtask

    task put_data(input mem_addr_t a, input word_t d);
        memory.words[a] = d;
        exp_mem[a] = d;
    endtask

    task check_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task check_flag(input string what, input logic expected, input logic actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("ERROR %s %s: expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task reset_cpu();
        cycle_budget += 6;
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_word("mem_cmd after reset", 16'(mem_none), 16'(mem_cmd));
        @(negedge clk);
        check_word("first fetch command", 16'(mem_read), 16'(mem_cmd));
        check_word("first fetch address", 16'h0000, 16'(mem_addr));
    endtask

    // stop word is fetched, then the bus has to stay quiet
    task wait_stop(input mem_addr_t stop_addr);
        int idle;
        int busy_at;
        cycle_budget += 18;
        @(negedge clk);
        while (!(mem_cmd == mem_read && mem_addr == stop_addr))
            @(negedge clk);
        @(negedge clk);   // fetch2 of the same word
        busy_at = 0;
        for (idle = 1; idle <= 16; idle++)
        begin
            @(negedge clk);
            if (busy_at == 0 && mem_cmd != mem_none)
                busy_at = idle;
        end
        check_count++;
        assert (busy_at == 0)
        else
        begin
            error_count++;
            $display("%s: memory command seen %0d cycles after the stop fetch",
                     test_name, busy_at);
        end
    endtask

    task run_program(input mem_addr_t stop_addr);
        int i;
        reset_cpu();
        wait_stop(stop_addr);
        for (i = 0; i < (1 << addr_width); i++)
            check_word($sformatf("mem[%h]", i), exp_mem[i], memory.words[i]);
    endtask

    task test_moves();
        word_t      r;
        logic [7:0] imm_pos;
        logic [7:0] imm_neg;
        word_t      neg;
        r = random_bits(7);
        imm_pos = r[7:0];
        r = random_bits(7);
        imm_neg = 8'h80 | r[7:0];
        neg = {8'hff, imm_neg};
        new_program("moves");
        emit(mov_imm_instr(3'd7, 8'h40));
        emit(mov_imm_instr(3'd0, imm_pos));
        emit(mov_imm_instr(3'd1, imm_neg));
        emit(mov_reg_instr(3'd2, shift_none, 3'd1));
        emit(mov_reg_instr(3'd3, shift_left, 3'd1));
        emit(mov_reg_instr(3'd4, shift_lsr, 3'd1));
        emit(mov_reg_instr(3'd5, shift_asr, 3'd1));
        emit(str_instr(3'd0, 3'd7, 5'd0));
        emit(str_instr(3'd1, 3'd7, 5'd1));
        emit(str_instr(3'd2, 3'd7, 5'd2));
        emit(str_instr(3'd3, 3'd7, 5'd3));
        emit(str_instr(3'd4, 3'd7, 5'd4));
        emit(str_instr(3'd5, 3'd7, 5'd5));
        emit(16'he000);
        exp_mem[9'h40] = {8'h00, imm_pos};
        exp_mem[9'h41] = neg;
        exp_mem[9'h42] = shifted(neg, shift_none);
        exp_mem[9'h43] = shifted(neg, shift_left);
        exp_mem[9'h44] = shifted(neg, shift_lsr);
        exp_mem[9'h45] = shifted(neg, shift_asr);
        run_program(prog_pc - 1'b1);
    endtask

    task test_alu();
        word_t a;
        word_t b;
        a = random_bits(16);
        b = random_bits(16);
        new_program("alu");
        put_data(9'h50, a);
        put_data(9'h51, b);
        emit(mov_imm_instr(3'd7, 8'h50));
        emit(ldr_instr(3'd0, 3'd7, 5'd0));
        emit(ldr_instr(3'd1, 3'd7, 5'd1));
        emit(alu_instr(2'b00, 3'd0, 3'd2, shift_none, 3'd1));   // add
        emit(alu_instr(2'b10, 3'd0, 3'd3, shift_left, 3'd1));   // and
        emit(alu_instr(2'b11, 3'd0, 3'd4, shift_asr, 3'd1));    // mvn
        emit(alu_instr(2'b00, 3'd0, 3'd5, shift_lsr, 3'd1));
        emit(alu_instr(2'b10, 3'd1, 3'd6, shift_none, 3'd0));
        emit(str_instr(3'd2, 3'd7, 5'd4));
        emit(str_instr(3'd3, 3'd7, 5'd5));
        emit(str_instr(3'd4, 3'd7, 5'd6));
        emit(str_instr(3'd5, 3'd7, 5'd7));
        emit(str_instr(3'd6, 3'd7, 5'd8));
        emit(16'he000);
        exp_mem[9'h54] = a + b;
        exp_mem[9'h55] = a & shifted(b, shift_left);
        exp_mem[9'h56] = ~shifted(b, shift_asr);
        exp_mem[9'h57] = a + shifted(b, shift_lsr);
        exp_mem[9'h58] = b & a;
        run_program(prog_pc - 1'b1);
    endtask

    task test_compare(input string name, input word_t a, input word_t b, input shift_e sh);
        word_t bs;
        word_t diff;
        int    sdiff;
        bs = shifted(b, sh);
        diff = a - bs;
        sdiff = int'($signed(a)) - int'($signed(bs));
        new_program(name);
        put_data(9'h60, a);
        put_data(9'h61, b);
        emit(mov_imm_instr(3'd7, 8'h60));
        emit(mov_imm_instr(3'd5, 8'h35));    // named as Rd of the compare
        emit(ldr_instr(3'd0, 3'd7, 5'd0));
        emit(ldr_instr(3'd1, 3'd7, 5'd1));
        emit(alu_instr(2'b01, 3'd0, 3'd5, sh, 3'd1));
        emit(str_instr(3'd0, 3'd7, 5'd2));   // operands must survive the compare
        emit(str_instr(3'd1, 3'd7, 5'd3));
        emit(str_instr(3'd5, 3'd7, 5'd4));
        emit(16'he000);
        exp_mem[9'h62] = a;
        exp_mem[9'h63] = b;
        exp_mem[9'h64] = 16'h0035;
        run_program(prog_pc - 1'b1);
        check_flag("z", diff == '0, z);
        check_flag("n", diff[15], n);
        check_flag("v", (sdiff > 32767) || (sdiff < -32768), v);
    endtask

    task test_addressing();
        word_t d0;
        word_t d1;
        d0 = random_bits(16);
        d1 = random_bits(16);
        new_program("addressing");
        put_data(9'h5d, d0);
        put_data(9'h65, d1);
        emit(mov_imm_instr(3'd7, 8'h60));
        emit(mov_imm_instr(3'd6, 8'hf0));      // negative base that wraps to 0x1f0
        emit(ldr_instr(3'd0, 3'd7, 5'h1d));    // -3
        emit(ldr_instr(3'd1, 3'd7, 5'd5));
        emit(str_instr(3'd0, 3'd7, 5'd15));
        emit(str_instr(3'd1, 3'd7, 5'h10));    // -16
        emit(str_instr(3'd0, 3'd6, 5'd2));
        emit(16'he000);
        exp_mem[9'h6f] = d0;
        exp_mem[9'h50] = d1;
        exp_mem[9'h1f2] = d0;
        run_program(prog_pc - 1'b1);
    endtask

    // dropped opcodes stop the processor like halt does
    task test_stop(input string name, input logic [2:0] opcode);
        mem_addr_t stop_addr;
        new_program(name);
        emit(mov_imm_instr(3'd7, 8'h70));
        emit(mov_imm_instr(3'd0, 8'h11));
        stop_addr = prog_pc;
        emit({opcode, 13'h0004});
        emit(str_instr(3'd0, 3'd7, 5'd0));     // never reached
        emit(16'he000);
        run_program(stop_addr);
    endtask

    initial
    begin
        word_t r;
        reset = 1'b1;
        test_moves();
        test_alu();
        r = random_bits(16);
        test_compare("compare zero", r, r, shift_none);
        r = random_bits(12);
        test_compare("compare negative", r, r + 16'h0100, shift_none);
        test_compare("compare overflow", 16'h7000 | random_bits(12),
                     16'h8000 | random_bits(12), shift_none);
        r = random_bits(15);
        test_compare("compare shifted", {r[14:0], 1'b0}, r, shift_left);
        test_addressing();
        test_stop("branch opcode", 3'b001);
        test_stop("conditional branch opcode", 3'b010);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        while (cycle_count <= 2 * cycle_budget)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles in %s, stop instruction never reached",
                 cycle_count, test_name);
        $display("%0d checks, %0d errors", check_count, error_count);
        $display("Checks failed");
        $finish;
    end

endmodule

/* cpu.f */
source/isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/datapath_ctrl_if.sv
source/instr_fields_if.sv
source/instr_decoder.sv
source/cpu_controller.sv
source/datapath.sv
source/address_unit.sv
source/cpu.sv
tests/tb_memory.sv
tests/tb_cpu.sv
